/* all.f */
src/phy_rx_pkg.sv
src/rx_block_lock.sv
src/rx_block_decode.sv
src/rx_ber_monitor.sv
src/phy_rx_lane.sv
verif/phy_rx_lane_asserts.sv
verif/tb_phy_rx_lane.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the receive lane testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_phy_rx_lane \
    -f all.f -o tb_phy_rx_lane > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_phy_rx_lane > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1

/* src/phy_rx_lane.sv */
////////////////////
// Receive half of one 10GBASE-R lane.
// Single clock domain; xgmii_valid trails serdes_rx_valid by 2 cycles.
////////////////////
module phy_rx_lane (
    input  logic                                    gt_rxusrclk,
    input  logic                                    gt_tx_reset,
    input  logic [phy_rx_pkg::PAYLOAD_WIDTH-1:0]    serdes_rx_data,
    input  logic [phy_rx_pkg::HDR_WIDTH-1:0]        serdes_rx_hdr,
    input  logic                                    serdes_rx_valid,
    output logic [phy_rx_pkg::XGMII_WIDTH-1:0]      xgmii_rxd,
    output logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0] xgmii_rxc,
    output logic                                    xgmii_valid,
    output logic                                    serdes_rx_bitslip,
    output logic                                    rx_block_lock,
    output logic                                    rx_high_ber
);

    phy_rx_pkg::block_payload_u blk_payload;
    logic                       blk_is_ctrl;
    logic                       blk_error;
    logic                       blk_valid;
    logic                       hdr_valid_strobe;
    logic                       hdr_invalid_strobe;

    rx_block_lock u_block_lock (
        .gt_rxusrclk        (gt_rxusrclk),
        .gt_tx_reset        (gt_tx_reset),
        .serdes_rx_data     (serdes_rx_data),
        .serdes_rx_hdr      (serdes_rx_hdr),
        .serdes_rx_valid    (serdes_rx_valid),
        .blk_payload        (blk_payload),
        .blk_is_ctrl        (blk_is_ctrl),
        .blk_error          (blk_error),
        .blk_valid          (blk_valid),
        .hdr_valid_strobe   (hdr_valid_strobe),
        .hdr_invalid_strobe (hdr_invalid_strobe),
        .serdes_rx_bitslip  (serdes_rx_bitslip),
        .rx_block_lock      (rx_block_lock)
    );

    rx_block_decode u_block_decode (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .blk_payload (blk_payload),
        .blk_is_ctrl (blk_is_ctrl),
        .blk_error   (blk_error),
        .blk_valid   (blk_valid),
        .xgmii_rxd   (xgmii_rxd),
        .xgmii_rxc   (xgmii_rxc),
        .xgmii_valid (xgmii_valid)
    );

    rx_ber_monitor u_ber_monitor (
        .gt_rxusrclk        (gt_rxusrclk),
        .gt_tx_reset        (gt_tx_reset),
        .hdr_valid_strobe   (hdr_valid_strobe),
        .hdr_invalid_strobe (hdr_invalid_strobe),
        .rx_high_ber        (rx_high_ber)
    );

endmodule

/* src/phy_rx_pkg.sv */
////////////////////
// Shared constants and types for one 10GBASE-R receive lane.
// Payloads arrive already descrambled. Any idle/control block type decodes
// as eight idles, and non-idle control codes are not carried.
////////////////////
package phy_rx_pkg;

    // Widths
    localparam int HDR_WIDTH        = 2;
    localparam int PAYLOAD_WIDTH    = 64;
    localparam int XGMII_WIDTH      = 64;
    localparam int XGMII_CTRL_WIDTH = 8;

    // Sync headers
    localparam logic [HDR_WIDTH-1:0] SYNC_DATA = 2'b01;
    localparam logic [HDR_WIDTH-1:0] SYNC_CTRL = 2'b10;

    // Block type field of control blocks
    localparam logic [7:0] BLK_TYPE_CTRL    = 8'h1e;
    localparam logic [7:0] BLK_TYPE_START_0 = 8'h78;
    localparam logic [7:0] BLK_TYPE_TERM_0  = 8'h87;
    localparam logic [7:0] BLK_TYPE_TERM_1  = 8'h99;
    localparam logic [7:0] BLK_TYPE_TERM_2  = 8'haa;
    localparam logic [7:0] BLK_TYPE_TERM_3  = 8'hb4;
    localparam logic [7:0] BLK_TYPE_TERM_4  = 8'hcc;
    localparam logic [7:0] BLK_TYPE_TERM_5  = 8'hd2;
    localparam logic [7:0] BLK_TYPE_TERM_6  = 8'he1;
    localparam logic [7:0] BLK_TYPE_TERM_7  = 8'hff;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // Block lock
    localparam int LOCK_COUNT      = 64;
    localparam int LOCK_WINDOW     = 64;
    localparam int LOCK_LOSS_LIMIT = 16;
    localparam int LOCK_CNT_WIDTH  =
        $clog2(LOCK_COUNT > LOCK_WINDOW ? LOCK_COUNT : LOCK_WINDOW);

    // Bit error rate monitor
    localparam int BER_WINDOW    = 128;
    localparam int BER_LIMIT     = 16;
    localparam int BER_CNT_WIDTH = $clog2(BER_WINDOW);

    // Same 64 bits, read as bytes for data blocks or as type plus body
    // for control blocks
    typedef union packed {
        logic [PAYLOAD_WIDTH/8-1:0][7:0] data;
        struct packed {
            logic [PAYLOAD_WIDTH-9:0] body;
            logic [7:0]               blk_type;
        } ctrl;
    } block_payload_u;

endpackage

/* src/rx_ber_monitor.sv */
////////////////////
// High bit error rate flag, evaluated once per window of blocks.
// Flag holds its value until the next window closes.
////////////////////
module rx_ber_monitor (
    input  logic gt_rxusrclk,
    input  logic gt_tx_reset,
    input  logic hdr_valid_strobe,
    input  logic hdr_invalid_strobe,
    output logic rx_high_ber
);

    logic                                 blk_strobe;
    logic [phy_rx_pkg::BER_CNT_WIDTH-1:0] blk_cnt;
    logic [phy_rx_pkg::BER_CNT_WIDTH-1:0] err_cnt;

    assign blk_strobe = hdr_valid_strobe || hdr_invalid_strobe;

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rx_high_ber <= 1'b0;
            blk_cnt     <= '0;
            err_cnt     <= '0;
        end else if (blk_strobe) begin
            if (int'(blk_cnt) == phy_rx_pkg::BER_WINDOW - 1) begin
                // Last block of the window counts toward the verdict
                rx_high_ber <= int'(err_cnt) + int'(hdr_invalid_strobe) >=
                               phy_rx_pkg::BER_LIMIT;
                blk_cnt     <= '0;
                err_cnt     <= '0;
            end else begin
                blk_cnt <= blk_cnt + 1'b1;
                if (hdr_invalid_strobe) begin
                    err_cnt <= err_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* src/rx_block_decode.sv */
////////////////////
// 64b/66b block to XGMII word.
// Idle/control type maps to eight idles only. Unknown types and
// flagged blocks come out as eight error characters.
////////////////////
module rx_block_decode (
    input  logic                                    gt_rxusrclk,
    input  logic                                    gt_tx_reset,
    input  phy_rx_pkg::block_payload_u              blk_payload,
    input  logic                                    blk_is_ctrl,
    input  logic                                    blk_error,
    input  logic                                    blk_valid,
    output logic [phy_rx_pkg::XGMII_WIDTH-1:0]      xgmii_rxd,
    output logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0] xgmii_rxc,
    output logic                                    xgmii_valid
);

    logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0][7:0] lane_d;
    logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0]      lane_c;
    logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0][7:0] body_lanes;
    int                                           term_lane;

    // Body bytes realigned to lane 0
    assign body_lanes = {8'h00, blk_payload.ctrl.body};

    always_comb begin
        lane_d    = {phy_rx_pkg::XGMII_CTRL_WIDTH{phy_rx_pkg::XGMII_ERROR}};
        lane_c    = '1;
        term_lane = -1;
        if (!blk_error) begin
            if (!blk_is_ctrl) begin
                lane_d = blk_payload.data;
                lane_c = '0;
            end else begin
                case (blk_payload.ctrl.blk_type)
                    phy_rx_pkg::BLK_TYPE_CTRL: begin
                        lane_d = {phy_rx_pkg::XGMII_CTRL_WIDTH{phy_rx_pkg::XGMII_IDLE}};
                    end
                    phy_rx_pkg::BLK_TYPE_START_0: begin
                        lane_d = {blk_payload.ctrl.body, phy_rx_pkg::XGMII_START};
                        lane_c = 8'h01;
                    end
                    phy_rx_pkg::BLK_TYPE_TERM_0: term_lane = 0;
                    phy_rx_pkg::BLK_TYPE_TERM_1: term_lane = 1;
                    phy_rx_pkg::BLK_TYPE_TERM_2: term_lane = 2;
                    phy_rx_pkg::BLK_TYPE_TERM_3: term_lane = 3;
                    phy_rx_pkg::BLK_TYPE_TERM_4: term_lane = 4;
                    phy_rx_pkg::BLK_TYPE_TERM_5: term_lane = 5;
                    phy_rx_pkg::BLK_TYPE_TERM_6: term_lane = 6;
                    phy_rx_pkg::BLK_TYPE_TERM_7: term_lane = 7;
                    default: begin
                        // Unknown type keeps the error word
                    end
                endcase
            end
        end

        // Data below the terminate, idles above it
        if (term_lane >= 0) begin
            for (int i = 0; i < phy_rx_pkg::XGMII_CTRL_WIDTH; i++) begin
                if (i < term_lane) begin
                    lane_d[i] = body_lanes[i];
                    lane_c[i] = 1'b0;
                end else if (i == term_lane) begin
                    lane_d[i] = phy_rx_pkg::XGMII_TERM;
                    lane_c[i] = 1'b1;
                end else begin
                    lane_d[i] = phy_rx_pkg::XGMII_IDLE;
                    lane_c[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            xgmii_valid <= 1'b0;
        end else begin
            xgmii_valid <= blk_valid;
        end
    end

    always_ff @(posedge gt_rxusrclk) begin
        if (blk_valid) begin
            xgmii_rxd <= lane_d;
            xgmii_rxc <= lane_c;
        end
    end

endmodule

/* src/rx_block_lock.sv */
////////////////////
// Sync header check and block lock FSM.
// One serdes_rx_valid strobe per block, no back-pressure.
// Bitslip pulses only while unlocked; outputs lag input by one cycle.
////////////////////
module rx_block_lock (
    input  logic                                  gt_rxusrclk,
    input  logic                                  gt_tx_reset,
    input  logic [phy_rx_pkg::PAYLOAD_WIDTH-1:0]  serdes_rx_data,
    input  logic [phy_rx_pkg::HDR_WIDTH-1:0]      serdes_rx_hdr,
    input  logic                                  serdes_rx_valid,
    output phy_rx_pkg::block_payload_u            blk_payload,
    output logic                                  blk_is_ctrl,
    output logic                                  blk_error,
    output logic                                  blk_valid,
    output logic                                  hdr_valid_strobe,
    output logic                                  hdr_invalid_strobe,
    output logic                                  serdes_rx_bitslip,
    output logic                                  rx_block_lock
);

    logic                                  hdr_ok;
    logic                                  lock_next;
    logic                                  lock_loss;
    logic [phy_rx_pkg::LOCK_CNT_WIDTH-1:0] lock_cnt;
    logic [phy_rx_pkg::LOCK_CNT_WIDTH-1:0] win_cnt;
    logic [phy_rx_pkg::LOCK_CNT_WIDTH-1:0] err_cnt;

    assign hdr_ok = (serdes_rx_hdr == phy_rx_pkg::SYNC_DATA) ||
                    (serdes_rx_hdr == phy_rx_pkg::SYNC_CTRL);

    // Bad header that fills the loss budget of the current window
    assign lock_loss = rx_block_lock && !hdr_ok &&
                       (int'(err_cnt) == phy_rx_pkg::LOCK_LOSS_LIMIT - 1);

    always_comb begin
        lock_next = rx_block_lock;
        if (serdes_rx_valid) begin
            if (!rx_block_lock) begin
                lock_next = hdr_ok && (int'(lock_cnt) == phy_rx_pkg::LOCK_COUNT - 1);
            end else if (lock_loss) begin
                lock_next = 1'b0;
            end
        end
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rx_block_lock      <= 1'b0;
            serdes_rx_bitslip  <= 1'b0;
            blk_valid          <= 1'b0;
            hdr_valid_strobe   <= 1'b0;
            hdr_invalid_strobe <= 1'b0;
            lock_cnt           <= '0;
            win_cnt            <= '0;
            err_cnt            <= '0;
        end else begin
            rx_block_lock      <= lock_next;
            serdes_rx_bitslip  <= 1'b0;
            blk_valid          <= serdes_rx_valid;
            hdr_valid_strobe   <= serdes_rx_valid && hdr_ok;
            hdr_invalid_strobe <= serdes_rx_valid && !hdr_ok;
            if (serdes_rx_valid) begin
                if (!rx_block_lock) begin
                    if (!hdr_ok) begin
                        lock_cnt          <= '0;
                        serdes_rx_bitslip <= 1'b1;
                    end else if (lock_next) begin
                        lock_cnt <= '0;
                    end else begin
                        lock_cnt <= lock_cnt + 1'b1;
                    end
                end else if (lock_loss ||
                             int'(win_cnt) == phy_rx_pkg::LOCK_WINDOW - 1) begin
                    win_cnt <= '0;
                    err_cnt <= '0;
                end else begin
                    win_cnt <= win_cnt + 1'b1;
                    if (!hdr_ok) begin
                        err_cnt <= err_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Staged block; error also covers a lane that is unlocked after this block
    always_ff @(posedge gt_rxusrclk) begin
        if (serdes_rx_valid) begin
            blk_payload <= serdes_rx_data;
            blk_is_ctrl <= serdes_rx_hdr == phy_rx_pkg::SYNC_CTRL;
            blk_error   <= !hdr_ok || !lock_next;
        end
    end

endmodule

/* verif/phy_rx_cases.txt */
// count mode hdr payload rxd rxc, all hex; a zero count ends the list
// mode 1 sends LFSR payloads (data or bad header only), payload and rxd unused
// idle, start in lane 0, data
01 0 2 000000000000001e 0707070707070707 ff
01 0 2 d555555555555578 d5555555555555fb 01
01 0 1 0123456789abcdef 0123456789abcdef 00
// terminate after 0 to 7 data bytes
01 0 2 7766554433221187 07070707070707fd ff
01 0 2 7766554433221199 070707070707fd11 fe
01 0 2 77665544332211aa 0707070707fd2211 fc
01 0 2 77665544332211b4 07070707fd332211 f8
01 0 2 77665544332211cc 070707fd44332211 f0
01 0 2 77665544332211d2 0707fd5544332211 e0
01 0 2 77665544332211e1 07fd665544332211 c0
01 0 2 77665544332211ff fd77665544332211 80
// unknown block type
01 0 2 7766554433221155 fefefefefefefefe ff
// random data, then 15 bad headers that keep lock
14 1 1 0000000000000000 0000000000000000 00
0f 1 0 0000000000000000 fefefefefefefefe ff
11 1 1 0000000000000000 0000000000000000 00
// 16 bad headers in one window drop lock, then slips while unlocked
10 1 3 0000000000000000 fefefefefefefefe ff
03 1 0 0000000000000000 fefefefefefefefe ff
// lock count restarts after a bad header
1e 1 1 0000000000000000 0000000000000000 00
01 1 3 0000000000000000 fefefefefefefefe ff
3f 1 1 0000000000000000 0000000000000000 00
01 0 2 000000000000001e 0707070707070707 ff
// close the noisy error-rate window, then one clean window
0e 1 1 0000000000000000 0000000000000000 00
80 1 1 0000000000000000 0000000000000000 00
00 0 0 0000000000000000 0000000000000000 00

/* verif/phy_rx_lane_asserts.sv */
////////////////////
// Bound into phy_rx_lane.
// Latency check assumes the fixed two-stage pipeline.
////////////////////
module phy_rx_lane_asserts (
    input logic gt_rxusrclk,
    input logic gt_tx_reset,
    input logic serdes_rx_valid,
    input logic xgmii_valid,
    input logic serdes_rx_bitslip,
    input logic rx_block_lock,
    input logic rx_high_ber
);

    valid_latency: assert property (
        @(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        xgmii_valid == $past(serdes_rx_valid, 2)
    ) else $error("xgmii_valid is not two cycles after serdes_rx_valid");

    // Slips are only requested while hunting for lock
    no_slip_in_lock: assert property (
        @(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        serdes_rx_bitslip |-> !rx_block_lock
    ) else $error("serdes_rx_bitslip pulsed while rx_block_lock was high");

    reset_outputs_low: assert property (
        @(posedge gt_rxusrclk)
        gt_tx_reset |-> !xgmii_valid && !serdes_rx_bitslip && !rx_block_lock && !rx_high_ber
    ) else $error("An output was high during reset");

endmodule

/* verif/tb_phy_rx_lane.sv */
////////////////////
// Testbench for phy_rx_lane. Blocks come from an LFSR lock-up prefix and
// from verif/phy_rx_cases.txt. Lock, bitslip and error-rate expectations
// come from reference models kept here.
////////////////////
module tb_phy_rx_lane;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int CASE_FIELDS  = 6;
    localparam int MAX_CASES    = 32;

    logic                                    gt_rxusrclk;
    logic                                    gt_tx_reset;
    logic [phy_rx_pkg::PAYLOAD_WIDTH-1:0]    serdes_rx_data;
    logic [phy_rx_pkg::HDR_WIDTH-1:0]        serdes_rx_hdr;
    logic                                    serdes_rx_valid;
    logic [phy_rx_pkg::XGMII_WIDTH-1:0]      xgmii_rxd;
    logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0] xgmii_rxc;
    logic                                    xgmii_valid;
    logic                                    serdes_rx_bitslip;
    logic                                    rx_block_lock;
    logic                                    rx_high_ber;

    // Six words per line as count, mode, header, payload, rxd and rxc
    logic [63:0] cases [0:MAX_CASES*CASE_FIELDS-1];
    logic [31:0] lfsr_state;
    int          n_blocks = 0;

    // Reference model state
    logic model_lock;
    logic model_ber;
    int   lock_run;
    int   win_blocks;
    int   win_errors;
    int   ber_blocks;
    int   ber_errors;

    logic [phy_rx_pkg::XGMII_WIDTH-1:0]      exp_rxd_q[$];
    logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0] exp_rxc_q[$];
    logic                                    exp_ber_q[$];

    phy_rx_lane uut (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .serdes_rx_data    (serdes_rx_data),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_valid   (serdes_rx_valid),
        .xgmii_rxd         (xgmii_rxd),
        .xgmii_rxc         (xgmii_rxc),
        .xgmii_valid       (xgmii_valid),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .rx_block_lock     (rx_block_lock),
        .rx_high_ber       (rx_high_ber)
    );

    bind phy_rx_lane phy_rx_lane_asserts u_asserts (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .serdes_rx_valid   (serdes_rx_valid),
        .xgmii_valid       (xgmii_valid),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .rx_block_lock     (rx_block_lock),
        .rx_high_ber       (rx_high_ber)
    );

    always #(CLK_PERIOD/2) gt_rxusrclk = ~gt_rxusrclk;

    task automatic stop_on_failure(input string reason);
        $display("Simulation FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_rxd(input logic [phy_rx_pkg::XGMII_WIDTH-1:0] got,
                             input logic [phy_rx_pkg::XGMII_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t xgmii_rxd got %h expected %h", $time, got, exp);
            stop_on_failure("xgmii_rxd mismatch");
        end
    endtask

    task automatic check_rxc(input logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0] got,
                             input logic [phy_rx_pkg::XGMII_CTRL_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t xgmii_rxc got %h expected %h", $time, got, exp);
            stop_on_failure("xgmii_rxc mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: time %0t %s got %b expected %b", $time, name, got, exp);
            stop_on_failure("status flag mismatch");
        end
    endtask

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic take_random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [63:0] random_bits(input int width);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[62:0], take_random_bit()};
        end
        return value;
    endfunction

    task automatic advance_lock_model(input logic hdr_ok);
        if (!model_lock) begin
            if (!hdr_ok) begin
                lock_run = 0;
            end else begin
                lock_run++;
                if (lock_run == phy_rx_pkg::LOCK_COUNT) begin
                    model_lock = 1'b1;
                    lock_run   = 0;
                end
            end
        end else begin
            win_blocks++;
            if (!hdr_ok) begin
                win_errors++;
            end
            if (win_errors == phy_rx_pkg::LOCK_LOSS_LIMIT) begin
                model_lock = 1'b0;
                win_blocks = 0;
                win_errors = 0;
            end else if (win_blocks == phy_rx_pkg::LOCK_WINDOW) begin
                win_blocks = 0;
                win_errors = 0;
            end
        end
    endtask

    task automatic advance_ber_model(input logic hdr_ok);
        ber_blocks++;
        if (!hdr_ok) begin
            ber_errors++;
        end
        if (ber_blocks == phy_rx_pkg::BER_WINDOW) begin
            model_ber  = (ber_errors >= phy_rx_pkg::BER_LIMIT);
            ber_blocks = 0;
            ber_errors = 0;
        end
    endtask

    // Called on a falling edge; returns on a falling edge after the gap
    task automatic send_block(input logic [phy_rx_pkg::HDR_WIDTH-1:0]     hdr,
                              input logic [phy_rx_pkg::PAYLOAD_WIDTH-1:0] payload,
                              input logic [phy_rx_pkg::XGMII_WIDTH-1:0]   file_rxd,
                              input logic [7:0]                           file_rxc,
                              input logic                                 from_file);
        logic hdr_ok;
        logic slip;
        int   gap;
        hdr_ok = (hdr == phy_rx_pkg::SYNC_DATA) || (hdr == phy_rx_pkg::SYNC_CTRL);
        slip   = !model_lock && !hdr_ok;
        advance_lock_model(hdr_ok);
        advance_ber_model(hdr_ok);
        if (!hdr_ok || !model_lock) begin
            exp_rxd_q.push_back({phy_rx_pkg::XGMII_CTRL_WIDTH{phy_rx_pkg::XGMII_ERROR}});
            exp_rxc_q.push_back('1);
        end else if (!from_file) begin
            exp_rxd_q.push_back(payload);
            exp_rxc_q.push_back('0);
        end else begin
            exp_rxd_q.push_back(file_rxd);
            exp_rxc_q.push_back(file_rxc);
        end
        exp_ber_q.push_back(model_ber);
        serdes_rx_hdr   = hdr;
        serdes_rx_data  = payload;
        serdes_rx_valid = 1'b1;
        @(negedge gt_rxusrclk);
        serdes_rx_valid = 1'b0;
        check_flag("rx_block_lock", rx_block_lock, model_lock);
        check_flag("serdes_rx_bitslip", serdes_rx_bitslip, slip);
        gap = int'(random_bits(2));
        repeat (gap) @(negedge gt_rxusrclk);
    endtask

    always @(negedge gt_rxusrclk) begin
        if (!gt_tx_reset && xgmii_valid) begin
            if (exp_rxd_q.size() == 0) begin
                stop_on_failure("xgmii_valid pulsed with no block outstanding");
            end else begin
                check_rxd(xgmii_rxd, exp_rxd_q.pop_front());
                check_rxc(xgmii_rxc, exp_rxc_q.pop_front());
                check_flag("rx_high_ber", rx_high_ber, exp_ber_q.pop_front());
            end
        end
    end

    initial begin
        wait (n_blocks > 0);
        #((n_blocks * 5 + 100) * CLK_PERIOD);
        stop_on_failure("Watchdog expired before all blocks came out");
    end

    initial begin
        int          n_cases;
        int          total;
        int          base;
        int          drain;
        logic [63:0] payload;
        gt_rxusrclk     = 1'b0;
        gt_tx_reset     = 1'b1;
        serdes_rx_data  = '0;
        serdes_rx_hdr   = '0;
        serdes_rx_valid = 1'b0;
        lfsr_state      = 32'h18b4;
        model_lock      = 1'b0;
        model_ber       = 1'b0;
        lock_run        = 0;
        win_blocks      = 0;
        win_errors      = 0;
        ber_blocks      = 0;
        ber_errors      = 0;

        $readmemh("verif/phy_rx_cases.txt", cases);
        if ($isunknown(cases[0]) || cases[0] == 0) begin
            stop_on_failure("Cases file is missing or holds no blocks");
        end
        // A zero count ends the list
        n_cases = 0;
        total   = phy_rx_pkg::LOCK_COUNT;
        while (n_cases < MAX_CASES && cases[n_cases*CASE_FIELDS] != 0) begin
            total += int'(cases[n_cases*CASE_FIELDS]);
            n_cases++;
        end
        n_blocks = total;

        repeat (RESET_CYCLES) @(negedge gt_rxusrclk);
        gt_tx_reset = 1'b0;
        @(negedge gt_rxusrclk);

        for (int i = 0; i < phy_rx_pkg::LOCK_COUNT; i++) begin
            payload = random_bits(phy_rx_pkg::PAYLOAD_WIDTH);
            send_block(phy_rx_pkg::SYNC_DATA, payload, '0, '0, 1'b0);
        end

        for (int c = 0; c < n_cases; c++) begin
            base = c * CASE_FIELDS;
            for (int r = 0; r < int'(cases[base]); r++) begin
                // Mode 1 swaps the file payload for LFSR data
                if (cases[base+1] != 0) begin
                    payload = random_bits(phy_rx_pkg::PAYLOAD_WIDTH);
                end else begin
                    payload = cases[base+3];
                end
                send_block(cases[base+2][phy_rx_pkg::HDR_WIDTH-1:0], payload,
                           cases[base+4], cases[base+5][7:0], cases[base+1] == 0);
            end
        end

        drain = 0;
        while (exp_rxd_q.size() != 0 && drain < 8) begin
            @(negedge gt_rxusrclk);
            drain++;
        end
        if (exp_rxd_q.size() != 0) begin
            stop_on_failure("Some blocks never produced an xgmii_valid strobe");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule
